//--- tb.f
+incdir+include
src/mips_pkg.sv
src/muldiv_if.sv
src/alu.sv
src/exec_pipe.sv
src/muldiv_arbiter.sv
src/muldiv_unit.sv
src/exec_top.sv
sim/tb_exec_top.sv

//--- Bender.yml
package:
  name: mips_exec

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/mips_pkg.sv
      - src/muldiv_if.sv
      - src/alu.sv
      - src/exec_pipe.sv
      - src/muldiv_arbiter.sv
      - src/muldiv_unit.sv
      - src/exec_top.sv
  - target: test
    files:
      - sim/tb_exec_top.sv

//--- sim/tb_exec_top.sv
`default_nettype none

module tb_exec_top;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    logic       clk = 1'b0;
    logic       rst;
    logic       flush;
    logic       valid_0, valid_1;
    exec_op_t   op_0, op_1;
    branch_t    br_0, br_1;
    word_t      srca_0, srca_1, srcb_0, srcb_1, imm_0, imm_1, pcplus4_0, pcplus4_1;
    logic       use_imm_0, use_imm_1;
    logic [4:0] shamt_0, shamt_1;
    word_t      result_0, result_1;
    logic       overflow_0, overflow_1, taken_0, taken_1, write_0, write_1, finish_0, finish_1;
    word_t      hi_m; // expected HI register.
    word_t      lo_m;

    exec_top i_dut (.*);

    always #2 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
            fail_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            fail_run($sformatf("Error: %s expected %b actual %b", name, expected, actual));
    endtask

    task automatic wait_finish(input int pipe);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < 100 && !seen; i++)
        begin
            @(negedge clk);
            seen = (pipe == 0) ? finish_0 : finish_1;
        end
        if (!seen)
            fail_run($sformatf("pipe %0d did not finish within 100 cycles", pipe));
    endtask

    task automatic drive_pipe(input int pipe, input logic v, input exec_op_t op,
                              input branch_t br, input word_t a, input word_t b,
                              input word_t imm, input logic ui, input logic [4:0] sh,
                              input word_t pc);
        if (pipe == 0)
        begin
            valid_0   = v;
            op_0      = op;
            br_0      = br;
            srca_0    = a;
            srcb_0    = b;
            imm_0     = imm;
            use_imm_0 = ui;
            shamt_0   = sh;
            pcplus4_0 = pc;
        end
        else
        begin
            valid_1   = v;
            op_1      = op;
            br_1      = br;
            srca_1    = a;
            srcb_1    = b;
            imm_1     = imm;
            use_imm_1 = ui;
            shamt_1   = sh;
            pcplus4_1 = pc;
        end
    endtask

    function automatic word_t alu_value(input exec_op_t op, input word_t a, input word_t b);
        int n;
        n = a[4:0];
        case (op)
            op_add, op_addu: return a + b;
            op_sub, op_subu: return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_nor:  return ~(a | b);
            op_slt:  return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b); // sign decides first.
            op_sltu: return word_t'(a < b);
            op_sll:  return b << n;
            op_srl:  return b >> n;
            op_sra:  return (b >> n) | (b[31] ? ~(32'hffff_ffff >> n) : 32'h0);
            op_clz, op_clo:
            begin
                n = 0;
                while (n < 32 && a[31 - n] == (op == op_clo))
                    n++;
                return n;
            end
            op_movz, op_movn: return a;
            default: return '0;
        endcase
    endfunction

    function automatic logic signed_overflow(input exec_op_t op, input word_t a, input word_t b);
        longint s;
        if (op == op_add)
            s = longint'($signed(a)) + longint'($signed(b));
        else if (op == op_sub)
            s = longint'($signed(a)) - longint'($signed(b));
        else
            return 1'b0;
        return s != longint'($signed(s[31:0])); // the exact sum does not fit in 32 bits.
    endfunction

    function automatic logic branch_cond(input branch_t br, input word_t a, input word_t b);
        case (br)
            br_eq:   return a == b;
            br_ne:   return a != b;
            br_ltz:  return $signed(a) < 0;
            br_gez:  return $signed(a) >= 0;
            br_gtz:  return $signed(a) > 0;
            br_lez:  return $signed(a) <= 0;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic write_enable(input exec_op_t op, input word_t b);
        if (op == op_movz)
            return b == '0;
        if (op == op_movn)
            return b != '0;
        return !(op inside {op_mult, op_multu, op_div, op_divu, op_madd, op_maddu, op_msub,
                            op_msubu, op_mthi, op_mtlo, op_nop});
    endfunction

    task automatic compare_alu_outputs(input string name, input int pipe, input exec_op_t op,
                                       input branch_t br, input word_t srca, input word_t srcb,
                                       input word_t imm, input logic ui, input logic [4:0] sh,
                                       input word_t pc);
        word_t a;
        word_t b;
        word_t y;
        a = (op inside {op_sll, op_srl, op_sra}) ? word_t'(sh) : srca;
        b = ui ? imm : srcb;
        y = (op == op_link) ? pc + 32'd4 : alu_value(op, a, b);
        check_word({name, " result"}, y, (pipe == 0) ? result_0 : result_1);
        check_bit({name, " overflow"}, signed_overflow(op, a, b),
                  (pipe == 0) ? overflow_0 : overflow_1);
        check_bit({name, " taken"}, branch_cond(br, srca, srcb), (pipe == 0) ? taken_0 : taken_1);
        check_bit({name, " write"}, write_enable(op, b), (pipe == 0) ? write_0 : write_1);
        check_bit({name, " finish"}, 1'b1, (pipe == 0) ? finish_0 : finish_1);
    endtask

    task automatic alu_corner(input string name, input exec_op_t op, input word_t a,
                              input word_t b);
        @(negedge clk);
        drive_pipe(0, 1'b1, op, br_none, a, b, 32'd0, 1'b0, a[4:0], 32'd0);
        wait_finish(0);
        compare_alu_outputs(name, 0, op, br_none, a, b, 32'd0, 1'b0, a[4:0], 32'd0);
    endtask

    task automatic alu_ops();
        exec_op_t   op_r [2];
        branch_t    br_r [2];
        word_t      a_r [2];
        word_t      b_r [2];
        word_t      imm_r [2];
        logic       ui_r [2];
        logic [4:0] sh_r [2];
        word_t      pc_r [2];
        for (int i = 0; i < 200; i++)
        begin
            for (int p = 0; p < 2; p++)
            begin
                op_r[p]  = exec_op_t'($urandom_range(17, 0)); // add through link.
                br_r[p]  = branch_t'($urandom_range(6, 0));
                a_r[p]   = $urandom();
                b_r[p]   = ($urandom_range(3, 0) == 0) ? 32'd0 : $urandom();
                imm_r[p] = ($urandom_range(3, 0) == 0) ? 32'd0 : $urandom();
                ui_r[p]  = $urandom_range(1, 0);
                sh_r[p]  = $urandom_range(31, 0);
                pc_r[p]  = $urandom() & 32'hffff_fffc;
            end
            @(negedge clk);
            for (int p = 0; p < 2; p++)
                drive_pipe(p, 1'b1, op_r[p], br_r[p], a_r[p], b_r[p], imm_r[p], ui_r[p],
                           sh_r[p], pc_r[p]);
            wait_finish(0);
            for (int p = 0; p < 2; p++)
                compare_alu_outputs($sformatf("alu %0d pipe %0d", i, p), p, op_r[p], br_r[p],
                                    a_r[p], b_r[p], imm_r[p], ui_r[p], sh_r[p], pc_r[p]);
        end
        @(negedge clk);
        valid_1 = 1'b0;
        alu_corner("add max", op_add, 32'h7fff_ffff, 32'd1);
        check_bit("add max flag", 1'b1, overflow_0);
        alu_corner("add min", op_add, 32'h8000_0000, 32'h8000_0000);
        alu_corner("addu max", op_addu, 32'h7fff_ffff, 32'd1);
        alu_corner("sub min", op_sub, 32'h8000_0000, 32'd1);
        alu_corner("sub max", op_sub, 32'h7fff_ffff, 32'hffff_ffff);
        alu_corner("clz zero", op_clz, 32'd0, 32'd0);
        check_word("clz zero count", 32'd32, result_0);
        alu_corner("clz ones", op_clz, 32'hffff_ffff, 32'd0);
        alu_corner("clo ones", op_clo, 32'hffff_ffff, 32'd0);
        alu_corner("clo zero", op_clo, 32'd0, 32'd0);
        alu_corner("clz mid", op_clz, 32'h0001_0000, 32'd0);
    endtask

    task automatic branch_write_link();
        word_t vals [3];
        vals = '{32'd0, 32'd5, 32'hffff_fffb};
        for (int c = 0; c < 7; c++)
            for (int i = 0; i < 3; i++)
                for (int j = 0; j < 3; j++)
                begin
                    @(negedge clk);
                    drive_pipe(1, 1'b1, op_addu, branch_t'(c), vals[i], vals[j], 32'd0, 1'b0,
                               5'd0, 32'd0);
                    wait_finish(1);
                    compare_alu_outputs($sformatf("branch %0d", c), 1, op_addu, branch_t'(c),
                                        vals[i], vals[j], 32'd0, 1'b0, 5'd0, 32'd0);
                end
        @(negedge clk);
        valid_1 = 1'b0;
        @(posedge clk);
        check_bit("branch idle", 1'b0, taken_1); // no decision without valid.
        alu_corner("movz zero", op_movz, 32'h1234_5678, 32'd0);
        alu_corner("movz nonzero", op_movz, 32'h1234_5678, 32'd7);
        alu_corner("movn zero", op_movn, 32'h0000_00aa, 32'd0);
        alu_corner("movn nonzero", op_movn, 32'h0000_00aa, 32'd7);
        alu_corner("nop", op_nop, 32'd1, 32'd2);
        @(negedge clk);
        drive_pipe(0, 1'b1, op_link, br_none, 32'd0, 32'd0, 32'd0, 1'b0, 5'd0, 32'h0040_0100);
        wait_finish(0);
        check_word("link", 32'h0040_0104, result_0);
        check_bit("link write", 1'b1, write_0);
    endtask

    task automatic md_issue(input string name, input int pipe, input exec_op_t op,
                            input word_t a, input word_t b, output word_t res);
        @(negedge clk);
        drive_pipe(pipe, 1'b1, op, br_none, a, b, 32'd0, 1'b0, 5'd0, 32'd0);
        wait_finish(pipe);
        res = (pipe == 0) ? result_0 : result_1;
        check_bit({name, " write"}, write_enable(op, b), (pipe == 0) ? write_0 : write_1);
        @(negedge clk);
        if (pipe == 0)
            valid_0 = 1'b0;
        else
            valid_1 = 1'b0;
    endtask

    task automatic read_hilo(input string name);
        word_t res;
        md_issue({name, " mfhi"}, 0, op_mfhi, 32'd0, 32'd0, res);
        check_word({name, " hi"}, hi_m, res);
        md_issue({name, " mflo"}, 0, op_mflo, 32'd0, 32'd0, res);
        check_word({name, " lo"}, lo_m, res);
    endtask

    task automatic mul_step(input string name, input exec_op_t op, input word_t a,
                            input word_t b);
        logic [63:0] p;
        word_t       res;
        if (op inside {op_mult, op_madd, op_msub})
            p = longint'($signed(a)) * longint'($signed(b));
        else
            p = {32'd0, a} * {32'd0, b};
        if (op inside {op_msub, op_msubu})
            {hi_m, lo_m} = {hi_m, lo_m} - p;
        else if (op inside {op_madd, op_maddu})
            {hi_m, lo_m} = {hi_m, lo_m} + p;
        else
            {hi_m, lo_m} = p;
        md_issue(name, 0, op, a, b, res);
        check_word(name, lo_m, res);
        read_hilo(name);
    endtask

    task automatic div_step(input string name, input exec_op_t op, input word_t a,
                            input word_t b);
        word_t res;
        if (b == '0)
        begin
            hi_m = a;
            lo_m = '1;
        end
        else if (op == op_div)
        begin
            lo_m = $signed(a) / $signed(b); // truncates toward zero.
            hi_m = $signed(a) % $signed(b);
        end
        else
        begin
            lo_m = a / b;
            hi_m = a % b;
        end
        md_issue(name, 0, op, a, b, res);
        check_word(name, lo_m, res);
        read_hilo(name);
    endtask

    task automatic move_step(input string name, input exec_op_t op, input word_t v);
        word_t res;
        if (op == op_mthi)
            hi_m = v;
        else
            lo_m = v;
        md_issue(name, 0, op, v, 32'd0, res);
        check_word(name, lo_m, res);
        read_hilo(name);
    endtask

    task automatic muldiv_hilo();
        read_hilo("reset");
        mul_step("mult neg", op_mult, 32'hffff_fff9, 32'd12345);
        mul_step("mult big", op_mult, 32'h8000_0000, 32'h7fff_ffff);
        mul_step("multu big", op_multu, 32'hffff_ffff, 32'hffff_ffff);
        mul_step("multu rand", op_multu, $urandom(), $urandom());
        div_step("div pos", op_div, 32'd100, 32'd7);
        div_step("div neg dividend", op_div, -32'sd100, 32'd7);
        div_step("div neg divisor", op_div, 32'd100, -32'sd7);
        div_step("div both neg", op_div, -32'sd100, -32'sd7);
        div_step("divu", op_divu, 32'hffff_fff0, 32'd3);
        div_step("div zero", op_div, 32'hffff_ff00, 32'd0);
        div_step("divu zero", op_divu, 32'd12345, 32'd0);
        move_step("mthi", op_mthi, 32'h1234_5678);
        move_step("mtlo", op_mtlo, 32'h9abc_def0);
    endtask

    task automatic accumulate();
        move_step("acc set hi", op_mthi, 32'h0000_0001);
        move_step("acc set lo", op_mtlo, 32'hffff_fff0);
        mul_step("madd", op_madd, -32'sd3, 32'd5);
        mul_step("maddu", op_maddu, 32'hffff_0000, 32'h0001_0000);
        mul_step("msub", op_msub, 32'h7fff_ffff, -32'sd2);
        mul_step("msubu", op_msubu, 32'h8000_0001, 32'd3);
    endtask

    task automatic contention();
        word_t       a0, b0, a1, b1, r0, r1;
        logic [63:0] p0, p1;
        bit          done0, done1;
        int          c0, c1;
        a0 = $urandom();
        b0 = $urandom();
        a1 = $urandom();
        b1 = $urandom();
        p0 = longint'($signed(a0)) * longint'($signed(b0));
        p1 = longint'($signed(a1)) * longint'($signed(b1));
        done0 = 1'b0;
        done1 = 1'b0;
        c0 = 0;
        c1 = 0;
        @(negedge clk);
        drive_pipe(0, 1'b1, op_mult, br_none, a0, b0, 32'd0, 1'b0, 5'd0, 32'd0);
        drive_pipe(1, 1'b1, op_mult, br_none, a1, b1, 32'd0, 1'b0, 5'd0, 32'd0);
        for (int i = 0; i < 100 && !(done0 && done1); i++)
        begin
            @(negedge clk);
            if (done0)
                valid_0 = 1'b0; // the cycle after its ack.
            if (!done0 && finish_0)
            begin
                done0 = 1'b1;
                c0    = i;
                r0    = result_0;
            end
            if (!done1 && finish_1)
            begin
                done1 = 1'b1;
                c1    = i;
                r1    = result_1;
            end
        end
        if (!(done0 && done1))
            fail_run("contention: a pipe did not finish within 100 cycles");
        if (c0 >= c1)
            fail_run("contention: pipe 0 did not finish before pipe 1");
        check_word("contention pipe 0", p0[31:0], r0);
        check_word("contention pipe 1", p1[31:0], r1);
        @(negedge clk);
        valid_0 = 1'b0;
        valid_1 = 1'b0;
        {hi_m, lo_m} = p1;
        read_hilo("contention");
    endtask

    task automatic flush_div();
        move_step("flush setup", op_mtlo, 32'h0bad_f00d);
        @(negedge clk);
        drive_pipe(1, 1'b1, op_div, br_none, 32'd1000, 32'd3, 32'd0, 1'b0, 5'd0, 32'd0);
        for (int i = 0; i < 6; i++)
        begin
            @(negedge clk);
            check_bit("flush busy finish", 1'b0, finish_1);
        end
        flush   = 1'b1;
        valid_1 = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        for (int i = 0; i < 40; i++)
        begin
            check_bit("flushed div finish", 1'b0, finish_1);
            @(negedge clk);
        end
        read_hilo("flush");
    endtask

    initial
    begin
        int seed;
        seed  = $urandom(31);
        rst   = 1'b1;
        flush = 1'b0;
        hi_m  = '0;
        lo_m  = '0;
        drive_pipe(0, 1'b0, op_nop, br_none, 32'd0, 32'd0, 32'd0, 1'b0, 5'd0, 32'd0);
        drive_pipe(1, 1'b0, op_nop, br_none, 32'd0, 32'd0, 32'd0, 1'b0, 5'd0, 32'd0);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        alu_ops();
        branch_write_link();
        muldiv_hilo();
        accumulate();
        contention();
        flush_div();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/exec_top.sv
`default_nettype none

module exec_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               valid_0,
    input  mips_pkg::exec_op_t op_0,
    input  mips_pkg::branch_t  br_0,
    input  mips_pkg::word_t    srca_0,
    input  mips_pkg::word_t    srcb_0,
    input  mips_pkg::word_t    imm_0,
    input  logic               use_imm_0,
    input  logic [4:0]         shamt_0,
    input  mips_pkg::word_t    pcplus4_0,
    output mips_pkg::word_t    result_0,
    output logic               overflow_0,
    output logic               taken_0,
    output logic               write_0,
    output logic               finish_0,
    input  logic               valid_1,
    input  mips_pkg::exec_op_t op_1,
    input  mips_pkg::branch_t  br_1,
    input  mips_pkg::word_t    srca_1,
    input  mips_pkg::word_t    srcb_1,
    input  mips_pkg::word_t    imm_1,
    input  logic               use_imm_1,
    input  logic [4:0]         shamt_1,
    input  mips_pkg::word_t    pcplus4_1,
    output mips_pkg::word_t    result_1,
    output logic               overflow_1,
    output logic               taken_1,
    output logic               write_1,
    output logic               finish_1
);

    muldiv_if bus_0 ();
    muldiv_if bus_1 ();
    muldiv_if bus_s ();

    exec_pipe u_pipe_0 (
        .clk (clk), .rst (rst), .flush (flush), .valid (valid_0), .op (op_0), .br (br_0),
        .srca (srca_0), .srcb (srcb_0), .imm (imm_0), .use_imm (use_imm_0),
        .shamt (shamt_0), .pcplus4 (pcplus4_0), .result (result_0),
        .overflow (overflow_0), .taken (taken_0), .write (write_0), .finish (finish_0),
        .bus (bus_0.master)
    );

    exec_pipe u_pipe_1 (
        .clk (clk), .rst (rst), .flush (flush), .valid (valid_1), .op (op_1), .br (br_1),
        .srca (srca_1), .srcb (srcb_1), .imm (imm_1), .use_imm (use_imm_1),
        .shamt (shamt_1), .pcplus4 (pcplus4_1), .result (result_1),
        .overflow (overflow_1), .taken (taken_1), .write (write_1), .finish (finish_1),
        .bus (bus_1.master)
    );

    muldiv_arbiter u_arbiter (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .m0    (bus_0.slave),
        .m1    (bus_1.slave),
        .s     (bus_s.master)
    );

    muldiv_unit u_muldiv (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .bus   (bus_s.slave)
    );

endmodule

`default_nettype wire

//--- src/muldiv_unit.sv
`default_nettype none

`include "mips_defines.svh"

module muldiv_unit (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    muldiv_if.slave bus
);
    import mips_pkg::*;

    muldiv_state_t    state_q;
    logic [5:0]       cnt_q;
    exec_op_t         op_q;
    word_t            a_q;
    word_t            b_q;
    word_t            hi_q;
    word_t            lo_q;
    logic [63:0]      prod_q;
    logic signed [63:0] prod_s;
    logic [63:0]      prod_u;
    logic [63:0]      product;
    logic [63:0]      acc;
    word_t            rem_q;
    word_t            quo_q;
    word_t            dvs_q;
    logic             neg_q;  // quotient sign.
    logic             rneg_q; // remainder takes the dividend sign.
    logic             dvz_q;
    logic [32:0]      trial;
    logic [32:0]      diff;
    word_t            rem_next;
    word_t            quo_next;
    logic             accept;
    logic             sgn;

    assign accept = bus.cyc && bus.stb && (state_q == st_idle) && !flush;
    assign sgn    = bus.op == op_div;

    assign prod_s  = $signed(a_q) * $signed(b_q);
    assign prod_u  = {32'b0, a_q} * {32'b0, b_q};
    assign product = (op_q inside {op_mult, op_madd, op_msub}) ? prod_s : prod_u;
    assign acc     = (op_q inside {op_msub, op_msubu}) ? {hi_q, lo_q} - prod_q
                                                       : {hi_q, lo_q} + prod_q;

    // one restoring step per cycle.
    assign trial    = {rem_q, quo_q[31]};
    assign diff     = trial - {1'b0, dvs_q};
    assign rem_next = diff[32] ? trial[31:0] : diff[31:0];
    assign quo_next = {quo_q[30:0], !diff[32]};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= st_idle;
            cnt_q   <= '0;
            hi_q    <= '0;
            lo_q    <= '0;
        end
        else if (flush)
            state_q <= st_idle; // HI and LO keep their old values.
        else
        begin
            case (state_q)
                st_idle:
                begin
                    if (accept)
                    begin
                        op_q <= bus.op;
                        a_q  <= bus.srca;
                        b_q  <= bus.srcb;
                        case (bus.op)
                            op_mult, op_multu:
                            begin
                                state_q <= st_mul;
                                cnt_q   <= 6'(`MUL_LAT - 1);
                            end
                            op_madd, op_maddu, op_msub, op_msubu:
                            begin
                                state_q <= st_mul;
                                cnt_q   <= 6'(`MUL_LAT);
                            end
                            op_div, op_divu:
                            begin
                                state_q <= st_div;
                                cnt_q   <= 6'(`DIV_STEPS);
                                rem_q   <= '0;
                                quo_q   <= (sgn && bus.srca[31]) ? -bus.srca : bus.srca;
                                dvs_q   <= (sgn && bus.srcb[31]) ? -bus.srcb : bus.srcb;
                                neg_q   <= sgn && (bus.srca[31] ^ bus.srcb[31]);
                                rneg_q  <= sgn && bus.srca[31];
                                dvz_q   <= (bus.srcb == '0);
                            end
                            op_mthi:
                            begin
                                hi_q    <= bus.srca;
                                state_q <= st_done;
                            end
                            op_mtlo:
                            begin
                                lo_q    <= bus.srca;
                                state_q <= st_done;
                            end
                            default: state_q <= st_done;
                        endcase
                    end
                end
                st_mul:
                begin
                    prod_q <= product;
                    cnt_q  <= cnt_q - 1'b1;
                    if (cnt_q == 6'd1)
                    begin
                        state_q <= st_done;
                        if (op_q inside {op_mult, op_multu})
                            {hi_q, lo_q} <= product;
                        else
                            {hi_q, lo_q} <= acc; // prod_q was loaded the cycle before.
                    end
                end
                st_div:
                begin
                    rem_q <= rem_next;
                    quo_q <= quo_next;
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == 6'd1)
                    begin
                        state_q <= st_done;
                        if (dvz_q)
                        begin
                            hi_q <= a_q;
                            lo_q <= '1;
                        end
                        else
                        begin
                            hi_q <= rneg_q ? -rem_next : rem_next;
                            lo_q <= neg_q ? -quo_next : quo_next;
                        end
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    assign bus.ack = (state_q == st_done);
    assign bus.hi  = hi_q;
    assign bus.lo  = lo_q;

    // the granted master keeps its request up while the unit works on it.
    assert property (@(posedge clk) disable iff (rst) (state_q != st_idle) && !flush |-> bus.cyc);

endmodule

`default_nettype wire

//--- src/muldiv_arbiter.sv
`default_nettype none

module muldiv_arbiter (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    muldiv_if.slave  m0,
    muldiv_if.slave  m1,
    muldiv_if.master s
);

    logic grant_q; // 0 selects m0, 1 selects m1.
    logic busy_q;
    logic sel;
    logic granted_cyc;

    assign sel         = busy_q ? grant_q : !m0.cyc; // m0 holds the older instruction.
    assign granted_cyc = grant_q ? m1.cyc : m0.cyc;

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            busy_q  <= 1'b0;
            grant_q <= 1'b0;
        end
        else if (!busy_q)
        begin
            if (m0.cyc || m1.cyc)
            begin
                busy_q  <= 1'b1;
                grant_q <= sel;
            end
        end
        else if (!granted_cyc)
            busy_q <= 1'b0;
    end

    assign s.cyc  = sel ? m1.cyc : m0.cyc;
    assign s.stb  = sel ? m1.stb : m0.stb;
    assign s.op   = sel ? m1.op : m0.op;
    assign s.srca = sel ? m1.srca : m0.srca;
    assign s.srcb = sel ? m1.srcb : m0.srcb;

    assign m0.ack = s.ack && !sel;
    assign m1.ack = s.ack && sel;
    assign m0.hi  = sel ? '0 : s.hi;
    assign m0.lo  = sel ? '0 : s.lo;
    assign m1.hi  = sel ? s.hi : '0;
    assign m1.lo  = sel ? s.lo : '0;

    // the unit answers only inside a held grant whose master is still waiting.
    assert property (@(posedge clk) disable iff (rst) s.ack |-> busy_q && granted_cyc);

endmodule

`default_nettype wire

//--- src/exec_pipe.sv
`default_nettype none

module exec_pipe (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               valid,
    input  mips_pkg::exec_op_t op,
    input  mips_pkg::branch_t  br,
    input  mips_pkg::word_t    srca,
    input  mips_pkg::word_t    srcb,
    input  mips_pkg::word_t    imm,
    input  logic               use_imm,
    input  logic [4:0]         shamt,
    input  mips_pkg::word_t    pcplus4,
    output mips_pkg::word_t    result,
    output logic               overflow,
    output logic               taken,
    output logic               write,
    output logic               finish,
    muldiv_if.master           bus
);
    import mips_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_y;
    logic  alu_ov;
    logic  is_md;
    logic  is_shift;
    logic  no_write;
    logic  cond;
    logic  block_q; // one idle cycle after ack or flush.

    assign is_shift = op inside {op_sll, op_srl, op_sra};
    assign is_md    = op inside {op_mult, op_multu, op_div, op_divu, op_madd, op_maddu,
                                 op_msub, op_msubu, op_mfhi, op_mflo, op_mthi, op_mtlo};
    assign no_write = op inside {op_mult, op_multu, op_div, op_divu, op_madd, op_maddu,
                                 op_msub, op_msubu, op_mthi, op_mtlo, op_nop};

    assign op_a = is_shift ? word_t'(shamt) : srca;
    assign op_b = use_imm ? imm : srcb;

    alu u_alu (
        .op       (op),
        .a        (op_a),
        .b        (op_b),
        .y        (alu_y),
        .overflow (alu_ov)
    );

    always_comb
    begin
        case (br)
            br_eq:   cond = (srca == srcb);
            br_ne:   cond = (srca != srcb);
            br_ltz:  cond = srca[31];
            br_gez:  cond = !srca[31];
            br_gtz:  cond = !srca[31] && (srca != '0);
            br_lez:  cond = srca[31] || (srca == '0);
            default: cond = 1'b0;
        endcase
    end

    assign taken = valid && cond;

    always_comb
    begin
        if (op == op_movz)
            write = valid && (op_b == '0);
        else if (op == op_movn)
            write = valid && (op_b != '0);
        else
            write = valid && !no_write;
    end

    always_comb
    begin
        if (op == op_link)
            result = pcplus4 + 32'd4;
        else if (op == op_mfhi)
            result = bus.hi;
        else if (is_md)
            result = bus.lo;
        else
            result = alu_y;
    end

    assign overflow = is_md ? 1'b0 : alu_ov;
    assign finish   = !is_md || bus.ack;

    always_ff @(posedge clk)
    begin
        if (rst)
            block_q <= 1'b0;
        else
            block_q <= bus.ack || flush;
    end

    assign bus.cyc  = valid && is_md && !block_q && !flush;
    assign bus.stb  = bus.cyc;
    assign bus.op   = op;
    assign bus.srca = op_a;
    assign bus.srcb = op_b;

    // a pending request holds its op and operands until ack or flush.
    assert property (@(posedge clk) disable iff (rst)
        bus.cyc && !bus.ack |=> flush || (bus.cyc && $stable(bus.op) && $stable(bus.srca) &&
                                          $stable(bus.srcb)));

endmodule

`default_nettype wire

//--- src/alu.sv
`default_nettype none

`include "mips_defines.svh"

module alu (
    input  mips_pkg::exec_op_t op,
    input  mips_pkg::word_t    a,
    input  mips_pkg::word_t    b,
    output mips_pkg::word_t    y,
    output logic               overflow
);
    import mips_pkg::*;

    word_t sum;
    word_t diff;

    // number of zero bits above the highest set bit, DATA_W for zero.
    function automatic word_t lead_zeros(input word_t w);
        word_t cnt;
        logic  found;
        cnt   = '0;
        found = 1'b0;
        for (int i = `DATA_W - 1; i >= 0; i--)
        begin
            if (!found)
            begin
                if (w[i])
                    found = 1'b1;
                else
                    cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    assign sum  = a + b;
    assign diff = a - b;

    always_comb
    begin
        y        = '0;
        overflow = 1'b0;
        case (op)
            op_add:
            begin
                y        = sum;
                overflow = (a[31] == b[31]) && (sum[31] != a[31]); // same signs in, other sign out.
            end
            op_addu: y = sum;
            op_sub:
            begin
                y        = diff;
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            op_subu: y = diff;
            op_and:  y = a & b;
            op_or:   y = a | b;
            op_xor:  y = a ^ b;
            op_nor:  y = ~(a | b);
            op_slt:  y = word_t'($signed(a) < $signed(b));
            op_sltu: y = word_t'(a < b);
            op_sll:  y = b << a[4:0];
            op_srl:  y = b >> a[4:0];
            op_sra:  y = $signed(b) >>> a[4:0];
            op_clz:  y = lead_zeros(a);
            op_clo:  y = lead_zeros(~a); // leading ones are leading zeros of the complement.
            op_movz, op_movn: y = a;
            default: y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/muldiv_if.sv
`default_nettype none

interface muldiv_if;
    import mips_pkg::*;

    logic     cyc;
    logic     stb;
    exec_op_t op;
    word_t    srca;
    word_t    srcb;
    logic     ack;
    word_t    hi; // HI after the operation, valid with ack.
    word_t    lo;

    modport master (output cyc, stb, op, srca, srcb, input ack, hi, lo);
    modport slave (input cyc, stb, op, srca, srcb, output ack, hi, lo);

endinterface

`default_nettype wire

//--- src/mips_pkg.sv
`default_nettype none

`include "mips_defines.svh"

package mips_pkg;

    typedef logic [`DATA_W-1:0] word_t;

    typedef enum logic [5:0] {
        op_add,
        op_addu,
        op_sub,
        op_subu,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        op_clz,
        op_clo,
        op_movz,
        op_movn,
        op_link,
        op_mult,
        op_multu,
        op_div,
        op_divu,
        op_madd,
        op_maddu,
        op_msub,
        op_msubu,
        op_mfhi,
        op_mflo,
        op_mthi,
        op_mtlo,
        op_nop
    } exec_op_t;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_ltz,
        br_gez,
        br_gtz,
        br_lez
    } branch_t;

    typedef enum logic [1:0] {
        st_idle,
        st_mul,
        st_div,
        st_done
    } muldiv_state_t;

endpackage

`default_nettype wire

//--- include/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define DATA_W 32     // datapath word width.
`define DIV_STEPS 32  // one quotient bit per divider iteration.
`define MUL_LAT 2     // cycles from accepted strobe to ack for mult.

`endif
